// ==== build.f ====
source/mul_pkg.sv
source/mul_issue_unit.sv
source/iter_mul_pipe.sv
source/mul_commit_unit.sv
source/mul_cluster.sv
verification/mul_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the multiply cluster testbench with Verilator
rm -f sim.log &&
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -f build.f \
  --top-module mul_cluster_tb -o mul_cluster_sim > build.log 2>&1 &&
./obj_dir/mul_cluster_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/iter_mul_pipe.sv ====
// Iterative multiplier pipe
// Radix-4 shift-add, one operation at a time, finishing early once the
// remaining multiplier bits are all zero

module iter_mul_pipe (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           disp_val,
  input  mul_pkg::word_t disp_a,
  input  mul_pkg::word_t disp_b,
  input  mul_pkg::seq_t  disp_seq,
  output logic           pipe_busy,
  output logic           res_val,
  output mul_pkg::seq_t  res_seq,
  output mul_pkg::word_t res_data
);

  mul_pkg::pipe_state_e state;
  // Step number of the current cycle, 1 .. MUL_STEPS
  mul_pkg::step_cnt_t   step_cnt;
  // Shifted multiplicand and multiplier, running sum
  mul_pkg::word_t       mcand;
  mul_pkg::word_t       mplier;
  mul_pkg::word_t       acc;
  mul_pkg::word_t       part_prod;
  mul_pkg::word_t       acc_next;
  mul_pkg::word_t       mplier_next;
  logic                 last_step;

  // --------------------
  // Datapath
  // --------------------

  // mcand times the low radix-4 digit
  always_comb begin
    case (mplier[1:0])
      2'd0:    part_prod = '0;
      2'd1:    part_prod = mcand;
      2'd2:    part_prod = mcand << 1;
      default: part_prod = mcand + (mcand << 1);
    endcase
  end

  assign acc_next    = acc + part_prod;
  assign mplier_next = mplier >> 2;
  // Stop when no nonzero digits remain
  assign last_step   = (mplier_next == '0) ||
                       (step_cnt == mul_pkg::step_cnt_t'(mul_pkg::MUL_STEPS));

  // Result leaves in the final step itself
  assign res_val   = (state == mul_pkg::PIPE_BUSY) && last_step;
  assign pipe_busy = (state == mul_pkg::PIPE_BUSY) && !last_step;
  assign res_data  = acc_next;

  // --------------------
  // FSM
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= mul_pkg::PIPE_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        mul_pkg::PIPE_IDLE: begin
          if (disp_val) begin
            state    <= mul_pkg::PIPE_BUSY;
            step_cnt <= mul_pkg::step_cnt_t'(1);
          end
        end
        default: begin
          if (last_step) begin
            state <= mul_pkg::PIPE_IDLE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Operand load on dispatch, shift while busy
  always_ff @(posedge clk) begin
    if (state == mul_pkg::PIPE_IDLE && disp_val) begin
      mcand   <= disp_a;
      mplier  <= disp_b;
      acc     <= '0;
      res_seq <= disp_seq;
    end else if (state == mul_pkg::PIPE_BUSY) begin
      mcand  <= mcand << 2;
      mplier <= mplier_next;
      acc    <= acc_next;
    end
  end

  // Issue unit only targets idle pipes
  assert property (@(posedge clk) disable iff (!arst_n)
    disp_val |-> state == mul_pkg::PIPE_IDLE);

endmodule

// ==== source/mul_cluster.sv ====
// Multiply cluster top level
// Issue unit feeding a bank of iterative multiplier pipes, drained in
// program order by the commit unit

module mul_cluster (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           op_val,
  input  mul_pkg::word_t op_a,
  input  mul_pkg::word_t op_b,
  output logic           issue_rdy,
  output logic           commit_val,
  output mul_pkg::seq_t  commit_seq,
  output mul_pkg::word_t commit_data
);

  // --------------------
  // Issue to pipes
  // --------------------

  mul_pkg::pipe_mask_t disp_val;
  mul_pkg::word_t      disp_a;
  mul_pkg::word_t      disp_b;
  mul_pkg::seq_t       disp_seq;
  mul_pkg::pipe_mask_t pipe_busy;

  // Pipes to commit
  mul_pkg::pipe_mask_t                     res_val;
  mul_pkg::seq_t [mul_pkg::NUM_PIPES-1:0]  res_seq;
  mul_pkg::word_t [mul_pkg::NUM_PIPES-1:0] res_data;

  mul_issue_unit u_issue (
    .clk        (clk),
    .arst_n     (arst_n),
    .op_val     (op_val),
    .op_a       (op_a),
    .op_b       (op_b),
    .pipe_busy  (pipe_busy),
    .commit_val (commit_val),
    .issue_rdy  (issue_rdy),
    .disp_val   (disp_val),
    .disp_a     (disp_a),
    .disp_b     (disp_b),
    .disp_seq   (disp_seq)
  );

  // One pipe per dispatch bit
  for (genvar g = 0; g < mul_pkg::NUM_PIPES; g++) begin : g_pipe
    iter_mul_pipe u_pipe (
      .clk       (clk),
      .arst_n    (arst_n),
      .disp_val  (disp_val[g]),
      .disp_a    (disp_a),
      .disp_b    (disp_b),
      .disp_seq  (disp_seq),
      .pipe_busy (pipe_busy[g]),
      .res_val   (res_val[g]),
      .res_seq   (res_seq[g]),
      .res_data  (res_data[g])
    );
  end

  mul_commit_unit u_commit (
    .clk         (clk),
    .arst_n      (arst_n),
    .res_val     (res_val),
    .res_seq     (res_seq),
    .res_data    (res_data),
    .commit_val  (commit_val),
    .commit_seq  (commit_seq),
    .commit_data (commit_data)
  );

endmodule

// ==== source/mul_commit_unit.sv ====
// Multiply commit unit
// Reorder buffer indexed by sequence number. Collects out-of-order
// pipe results and commits them in program order, one per cycle

module mul_commit_unit (
  input  logic                                     clk,
  input  logic                                     arst_n,
  input  mul_pkg::pipe_mask_t                      res_val,
  input  mul_pkg::seq_t [mul_pkg::NUM_PIPES-1:0]   res_seq,
  input  mul_pkg::word_t [mul_pkg::NUM_PIPES-1:0]  res_data,
  output logic                                     commit_val,
  output mul_pkg::seq_t                            commit_seq,
  output mul_pkg::word_t                           commit_data
);

  // --------------------
  // ROB storage
  // --------------------

  // Slot holds a finished result
  logic [mul_pkg::ROB_DEPTH-1:0] slot_val;
  mul_pkg::word_t                slot_data [mul_pkg::ROB_DEPTH];
  // Oldest uncommitted tag
  mul_pkg::seq_t                 head;

  // Commit as soon as the oldest result is present
  assign commit_val  = slot_val[head];
  assign commit_seq  = head;
  assign commit_data = slot_data[head];

  // --------------------
  // Valid bits and head
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_val <= '0;
      head     <= '0;
    end else begin
      // Retire head
      if (commit_val) begin
        slot_val[head] <= 1'b0;
        head           <= head + 1'b1;
      end
      // Fill from pipes, tags never collide
      for (int p = 0; p < mul_pkg::NUM_PIPES; p++) begin
        if (res_val[p]) begin
          slot_val[res_seq[p]] <= 1'b1;
        end
      end
    end
  end

  // Result words
  always_ff @(posedge clk) begin
    for (int p = 0; p < mul_pkg::NUM_PIPES; p++) begin
      if (res_val[p]) begin
        slot_data[res_seq[p]] <= res_data[p];
      end
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Issue side must not reuse a tag before it commits
  for (genvar p = 0; p < mul_pkg::NUM_PIPES; p++) begin : g_chk
    assert property (@(posedge clk) disable iff (!arst_n)
      res_val[p] |-> !slot_val[res_seq[p]]);
  end

endmodule

// ==== source/mul_issue_unit.sv ====
// Multiply issue unit
// Tags each operation with a sequence number, tracks free pipes and
// reorder slots, and dispatches to the lowest idle pipe

module mul_issue_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                op_val,
  input  mul_pkg::word_t      op_a,
  input  mul_pkg::word_t      op_b,
  input  mul_pkg::pipe_mask_t pipe_busy,
  input  logic                commit_val,
  output logic                issue_rdy,
  output mul_pkg::pipe_mask_t disp_val,
  output mul_pkg::word_t      disp_a,
  output mul_pkg::word_t      disp_b,
  output mul_pkg::seq_t       disp_seq
);

  // Next tag to hand out
  mul_pkg::seq_t next_seq;
  // Ops issued and not yet committed (0 .. ROB_DEPTH)
  logic [mul_pkg::SEQ_BITS:0] in_flight;
  // Pipes free to take an op this cycle
  mul_pkg::pipe_mask_t avail;
  mul_pkg::pipe_mask_t pick;

  // --------------------
  // Pipe selection
  // --------------------

  // A pipe dispatched last cycle does not show busy yet
  assign avail = ~pipe_busy & ~disp_val;

  // Lowest-numbered idle pipe wins
  always_comb begin
    pick = '0;
    for (int i = mul_pkg::NUM_PIPES - 1; i >= 0; i--) begin
      if (avail[i]) begin
        pick = mul_pkg::pipe_mask_t'(1) << i;
      end
    end
  end

  // Stall when all pipes busy or the ROB is full
  assign issue_rdy = (in_flight != mul_pkg::ROB_DEPTH) && (|avail);

  // --------------------
  // Dispatch registers
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      disp_val  <= '0;
      next_seq  <= '0;
      in_flight <= '0;
    end else begin
      disp_val <= op_val ? pick : '0;
      if (op_val) begin
        next_seq <= next_seq + 1'b1;
      end
      // Issue and commit may coincide
      case ({op_val, commit_val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Operands and tag shared by all pipes
  always_ff @(posedge clk) begin
    if (op_val) begin
      disp_a   <= op_a;
      disp_b   <= op_b;
      disp_seq <= next_seq;
    end
  end

  // Caller must respect issue_rdy
  assert property (@(posedge clk) disable iff (!arst_n) op_val |-> issue_rdy);
  // Every accepted op lands in exactly one pipe
  assert property (@(posedge clk) disable iff (!arst_n) op_val |=> $onehot(disp_val));

endmodule

// ==== source/mul_pkg.sv ====
// Multiply cluster package
// Shared sizes, vector types and the pipe state encoding for the
// issue unit, the iterative pipes and the reorder buffer

package mul_pkg;

  // --------------------
  // Cluster sizes
  // --------------------

  // Iterative multiplier pipes behind the issue unit
  localparam int NUM_PIPES  = 4;
  // Sequence number width, wraps modulo ROB_DEPTH
  localparam int SEQ_BITS   = 3;
  localparam int ROB_DEPTH  = 1 << SEQ_BITS;
  localparam int DATA_WIDTH = 32;
  // Two multiplier bits retired per step
  localparam int MUL_STEPS  = DATA_WIDTH / 2;

  // --------------------
  // Vector types
  // --------------------

  typedef logic [DATA_WIDTH-1:0]         word_t;
  typedef logic [SEQ_BITS-1:0]           seq_t;
  // One bit per pipe
  typedef logic [NUM_PIPES-1:0]          pipe_mask_t;
  // Holds 0 .. MUL_STEPS inclusive
  typedef logic [$clog2(MUL_STEPS):0]    step_cnt_t;

  // Pipe FSM
  typedef enum logic {
    PIPE_IDLE,
    PIPE_BUSY
  } pipe_state_e;

endpackage

// ==== verification/mul_cluster_tb.sv ====
// Multiply cluster testbench
// File-driven operations with random idle gaps, checked against the
// expected products in issue order, plus reset and back-pressure checks

module mul_cluster_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_OPS      = 64;
  // Columns per line: valid, op_a, op_b, product
  localparam int COLS         = 4;
  localparam int RESET_CYCLES = 16;
  // Leading ops issued back to back
  localparam int BURST_OPS    = 12;

  logic           clk;
  logic           arst_n;
  logic           op_val;
  mul_pkg::word_t op_a;
  mul_pkg::word_t op_b;
  logic           issue_rdy;
  logic           commit_val;
  mul_pkg::seq_t  commit_seq;
  mul_pkg::word_t commit_data;

  // Stimulus image and expected results
  mul_pkg::word_t stim_mem [MAX_OPS*COLS];
  mul_pkg::word_t exp_q [$];
  mul_pkg::seq_t  exp_seq;
  logic [31:0]    lcg_state;
  int             num_ops;
  int             err_cnt;
  int             commit_cnt;
  int             cycle_cnt;
  int             timeout_cycles;
  logic           run_started;
  logic           rdy_fell;

  mul_cluster dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .op_val      (op_val),
    .op_a        (op_a),
    .op_b        (op_b),
    .issue_rdy   (issue_rdy),
    .commit_val  (commit_val),
    .commit_seq  (commit_seq),
    .commit_data (commit_data)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Strobe one op once issue_rdy allows, returns with op_val low
  task automatic issue_op(input int idx);
    while (!issue_rdy) begin
      // Stall seen inside the zero-gap run
      if (idx < BURST_OPS) begin
        rdy_fell = 1'b1;
      end
      @(negedge clk);
    end
    op_val = 1'b1;
    op_a   = stim_mem[idx*COLS+1];
    op_b   = stim_mem[idx*COLS+2];
    exp_q.push_back(stim_mem[idx*COLS+3]);
    @(negedge clk);
    op_val = 1'b0;
  endtask

  task automatic report_counts();
    $display("Errors: %0d, commits: %0d of %0d", err_cnt, commit_cnt, num_ops);
  endtask

  // --------------------
  // Commit checker
  // --------------------

  always @(negedge clk) begin
    if (run_started && commit_val) begin
      if (exp_q.size() == 0) begin
        $display("Commit arrived with no operation outstanding");
        err_cnt++;
      end else begin
        if (commit_data != exp_q[0]) begin
          $display("Error: test product, expected 0x%08h, actual 0x%08h",
                   exp_q[0], commit_data);
          err_cnt++;
        end
        void'(exp_q.pop_front());
      end
      // Tags retire in program order
      if (commit_seq != exp_seq) begin
        $display("Error: test order, expected %0d, actual %0d", exp_seq, commit_seq);
        err_cnt++;
      end
      exp_seq = exp_seq + 1'b1;
      commit_cnt++;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    if (run_started) begin
      cycle_cnt++;
      if (cycle_cnt > timeout_cycles) begin
        $display("Timeout after %0d cycles with operations still outstanding", cycle_cnt);
        err_cnt++;
        report_counts();
        $display("Test failed");
        $finish;
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int gap;
    arst_n      = 1'b0;
    op_val      = 1'b0;
    op_a        = '0;
    op_b        = '0;
    err_cnt     = 0;
    commit_cnt  = 0;
    cycle_cnt   = 0;
    num_ops     = 0;
    exp_seq     = '0;
    lcg_state   = 32'h820d5b51;
    run_started = 1'b0;
    rdy_fell    = 1'b0;

    $readmemh("verification/mul_input.txt", stim_mem);
    while (num_ops < MAX_OPS && stim_mem[num_ops*COLS] == 32'd1) begin
      num_ops++;
    end
    if (num_ops == 0) begin
      $display("No operations were read from the input file");
      err_cnt++;
    end
    timeout_cycles = num_ops * 24 + 200;

    // No commit may leak out while in reset
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (commit_val) begin
        $display("commit_val went high during reset");
        err_cnt++;
      end
    end
    arst_n = 1'b1;
    @(negedge clk);
    if (commit_val) begin
      $display("commit_val went high in the cycle after reset release");
      err_cnt++;
    end
    if (!issue_rdy) begin
      $display("issue_rdy was low on the first falling edge after reset");
      err_cnt++;
    end
    run_started = 1'b1;

    for (int i = 0; i < num_ops; i++) begin
      if (i < BURST_OPS) begin
        gap = 0;
      end else begin
        lcg_state = lcg_next(lcg_state);
        gap = int'(lcg_state[17:16]);
      end
      repeat (gap) @(negedge clk);
      issue_op(i);
    end

    while (commit_cnt < num_ops) begin
      @(negedge clk);
    end
    // Room for a stray extra commit to show
    repeat (4) @(negedge clk);

    if (!rdy_fell) begin
      $display("issue_rdy never fell during the back-to-back run");
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results were never committed", exp_q.size());
      err_cnt++;
    end
    if (commit_cnt != num_ops) begin
      $display("Commit count does not match the number of operations");
      err_cnt++;
    end

    report_counts();
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verification/mul_input.txt ====
// Columns, all hex: valid op_a op_b product (low 32 bits of op_a * op_b)
// valid is 1 on every operation line, long ops have op_b bit 31 set
1 00000003 00000005 0000000f
1 12345678 00000000 00000000
1 12345678 00000001 12345678
1 00000000 deadbeef 00000000
1 ffffffff ffffffff 00000001
1 00000002 80000000 00000000
1 00000007 00000003 00000015
1 00000001 80000001 80000001
1 00000005 00000002 0000000a
1 ffffffff 00000002 fffffffe
1 00000003 80000000 80000000
1 00000010 00000010 00000100
1 00000100 00000100 00010000
1 0000ffff 0000ffff fffe0001
1 00010000 00010000 00000000
1 ffffffff 00000003 fffffffd
1 00000009 c0000000 c0000000
1 00000004 00000004 00000010
1 00001234 00000010 00012340
1 aaaaaaaa 00000003 fffffffe
1 00000001 ffffffff ffffffff
1 0000000b 00000001 0000000b
1 00000006 00000007 0000002a
1 ffffffff 80000000 80000000
1 00000002 00000003 00000006
1 00000000 00000000 00000000
1 00000008 00000008 00000040
1 87654321 00000002 0eca8642
1 00000003 a0000000 e0000000
1 0000000f 0000000f 000000e1
1 00000011 00000100 00001100
1 00000101 00000101 00010201
1 12345678 00000010 23456780
1 00000001 00000001 00000001
1 ffffffff 00000000 00000000
1 00000005 90000000 d0000000
